// File: verif/fwft_cases.txt
# wr_en wr_data inj rd_en, all hex, one line per clock cycle
# inj 0 none, 1 single flip, 2 double flip; gap settle drain waitfull are phase steps
# reads on an empty fifo
0 0000 0 1
0 0000 0 1
0 0000 0 0
# interleaved traffic with injected errors
1 1a01 0 0
1 1a02 1 0
1 1a03 0 1
0 0000 0 1
1 1a04 1 1
1 1a05 0 0
1 1a06 2 1
0 0000 0 1
1 1a07 0 1
1 1a08 1 1
0 0000 0 1
1 1a09 0 0
gap
drain
gap
# climb past the prog full thresholds
1 2b01 0 0
1 2b02 0 0
1 2b03 1 0
1 2b04 0 0
1 2b05 0 0
1 2b06 0 0
1 2b07 2 0
1 2b08 0 0
1 2b09 0 0
1 2b0a 0 0
settle
1 2b0b 0 0
1 2b0c 0 0
1 2b0d 1 0
1 2b0e 0 0
settle
# fill to full, then two dropped writes
1 3c01 0 0
1 3c02 0 0
1 3c03 0 0
1 3c04 0 0
1 3c05 0 0
1 3c06 0 0
waitfull
1 dead 0 0
1 beef 1 0
settle
# pop down through the hysteresis band
0 0000 0 1
0 0000 0 1
0 0000 0 1
0 0000 0 1
0 0000 0 1
0 0000 0 1
0 0000 0 1
0 0000 0 1
0 0000 0 1
settle
0 0000 0 1
settle
0 0000 0 1
settle
gap
drain

// File: files.f
+incdir+logic
logic/ecc_pkg.sv
logic/fifo_pkg.sv
logic/secded_codec.sv
logic/pipe_ram.sv
logic/bus_delay.sv
logic/fifo_core.sv
logic/fwft_fifo.sv
verif/fwft_fifo_tb.sv

// File: verif/fwft_fifo_tb.sv
`default_nettype none

`include "fifo_cfg.svh"

module fwft_fifo_tb import fifo_pkg::*; ();

   localparam int          SLOTS       = `FIFO_PRE_SLOTS;
   localparam int          DW          = `FIFO_DATA_WIDTH;
   localparam fifo_level_t PF_ASSERT   = 10;
   localparam fifo_level_t PF_NEGATE   = 6;
   localparam int          DRAIN_LIMIT = 200;
   localparam int          FULL_LIMIT  = 64;

   logic          clk = 1'b0;
   logic          rst_n;
   logic          wr_en, inj_single, inj_double, rd_en;
   logic [DW-1:0] wr_data;
   fifo_level_t   prog_full_assert_cfg, prog_full_negate_cfg;
   logic [DW-1:0] rd_data;
   logic          rd_data_val, empty, full, prog_full;
   logic          ovf_int, udf_int, single_err, double_err;

   logic [DW-1:0] exp_q [$];                        // words inside the fifo, oldest first
   bit            chk_q [$];                        // cleared for double injected words
   bit            mon_on, udf_exp, ovf_exp, pf_model, timed_out;
   int            val_errs, other_errs;
   int            sgl_inj, dbl_inj, sgl_seen, dbl_seen;
   int            fd, first_rand;
   string         line;

   always #20 clk = ~clk;

   fwft_fifo dut_i (
      .clk                  (clk),
      .rst_n                (rst_n),
      .wr_en                (wr_en),
      .inj_single           (inj_single),
      .inj_double           (inj_double),
      .rd_en                (rd_en),
      .wr_data              (wr_data),
      .prog_full_assert_cfg (prog_full_assert_cfg),
      .prog_full_negate_cfg (prog_full_negate_cfg),
      .rd_data              (rd_data),
      .rd_data_val          (rd_data_val),
      .empty                (empty),
      .full                 (full),
      .prog_full            (prog_full),
      .ovf_int              (ovf_int),
      .udf_int              (udf_int),
      .single_err           (single_err),
      .double_err           (double_err)
   );

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------

   task automatic flag_mismatch(input string sig, input logic [31:0] exp,
                                input logic [31:0] act);
      $display("ERROR at time %0t: %s expected 0x%0h, got 0x%0h", $time, sig, exp, act);
      val_errs++;
   endtask

   task automatic note_timeout(input string what, input int cycles);
      $display("timed out after %0d cycles waiting for %s", cycles, what);
      other_errs++;
      timed_out = 1'b1;
   endtask

   // inputs change just after the rising edge
   task automatic drive_line(input logic we, input logic [DW-1:0] data,
                             input logic [1:0] inj, input logic re);
      @(posedge clk);
      #2;
      wr_en      = we;
      wr_data    = data;
      inj_single = (inj == 2'd1);
      inj_double = (inj == 2'd2);
      rd_en      = re;
   endtask

   task automatic idle_cycle();
      logic [31:0] r;
      r = $urandom;
      drive_line(1'b0, r[DW-1:0], 2'd0, 1'b0);    // data toggles, no strobe
   endtask

   task automatic idle_gap();
      int k;
      k = $urandom % 4 + 1;
      repeat (k) idle_cycle();
   endtask

   // core level excludes the words parked in the prefetch slots
   task automatic settle_check();
      int lvl;
      repeat (16) idle_cycle();
      lvl = (exp_q.size() > SLOTS) ? exp_q.size() - SLOTS : 0;
      if (lvl >= PF_ASSERT) pf_model = 1'b1;
      else if (lvl < PF_NEGATE) pf_model = 1'b0;
      assert (prog_full == pf_model) else flag_mismatch("prog_full", pf_model, prog_full);
   endtask

   task automatic drain_fifo();
      int n;
      n = 0;
      while (exp_q.size() > 0 && n < DRAIN_LIMIT) begin
         drive_line(1'b0, '0, 2'd0, 1'b1);
         @(negedge clk);
         #1;                                        // scoreboard has moved by now
         n++;
      end
      if (exp_q.size() > 0) note_timeout("the fifo to drain", n);
      else pf_model = 1'b0;
      repeat (8) begin
         idle_cycle();
         assert (empty) else flag_mismatch("empty", 1'b1, empty);
      end
   endtask

   task automatic wait_for_full();
      int n;
      n = 0;
      while (!full && n < FULL_LIMIT) begin
         idle_cycle();
         n++;
      end
      if (!full) note_timeout("full", n);
   endtask

   task automatic check_reset_state();
      assert (!rd_data_val) else flag_mismatch("rd_data_val", 1'b0, rd_data_val);
      assert (empty) else flag_mismatch("empty", 1'b1, empty);
      assert (!full) else flag_mismatch("full", 1'b0, full);
      assert (!prog_full) else flag_mismatch("prog_full", 1'b0, prog_full);
      assert (!ovf_int) else flag_mismatch("ovf_int", 1'b0, ovf_int);
      assert (!udf_int) else flag_mismatch("udf_int", 1'b0, udf_int);
      assert (!single_err) else flag_mismatch("single_err", 1'b0, single_err);
      assert (!double_err) else flag_mismatch("double_err", 1'b0, double_err);
      assert (!dut_i.core_rd_en) else flag_mismatch("core_rd_en", 1'b0, dut_i.core_rd_en);
   endtask

   task automatic run_line(input string txt);
      string       kw;
      logic [31:0] we, data, inj, re;
      if (txt.len() > 1 && txt.getc(0) != "#" && $sscanf(txt, "%s", kw) == 1) begin
         if (kw == "gap") idle_gap();
         else if (kw == "settle") settle_check();
         else if (kw == "drain") drain_fifo();
         else if (kw == "waitfull") wait_for_full();
         else if ($sscanf(txt, "%h %h %h %h", we, data, inj, re) == 4)
            drive_line(we[0], data[DW-1:0], inj[1:0], re[0]);
         else begin
            $display("could not read this line of the cases file: %s", txt);
            other_errs++;
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // scoreboard, sampled mid cycle
   // ----------------------------------------------------------------------

   always @(negedge clk) begin
      if (mon_on) begin
         assert (empty == !rd_data_val) else flag_mismatch("empty", !rd_data_val, empty);
         assert (udf_int == udf_exp) else flag_mismatch("udf_int", udf_exp, udf_int);
         assert (ovf_int == ovf_exp) else flag_mismatch("ovf_int", ovf_exp, ovf_int);
         if (single_err) sgl_seen++;
         if (double_err) dbl_seen++;
         if (rd_data_val) begin
            assert (exp_q.size() > 0) else begin
               $display("output shows a word at time %0t but none was written", $time);
               other_errs++;
            end
            if (exp_q.size() > 0) begin
               if (chk_q[0]) begin                  // double errors leave garbage
                  assert (rd_data == exp_q[0]) else flag_mismatch("rd_data", exp_q[0], rd_data);
               end
               if (rd_en) begin
                  exp_q.delete(0);
                  chk_q.delete(0);
               end
            end
         end
         udf_exp = rd_en && !rd_data_val;
         ovf_exp = wr_en && full;
         if (wr_en && !full) begin
            exp_q.push_back(wr_data);
            chk_q.push_back(!inj_double);
            if (inj_single) sgl_inj++;
            if (inj_double) dbl_inj++;
         end
      end
   end

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------

   initial begin
      first_rand           = $urandom(32'h6778_24c4);
      rst_n                = 1'b0;
      wr_en                = 1'b0;
      inj_single           = 1'b0;
      inj_double           = 1'b0;
      rd_en                = 1'b0;
      wr_data              = '0;
      prog_full_assert_cfg = PF_ASSERT;
      prog_full_negate_cfg = PF_NEGATE;
      mon_on               = 1'b0;
      udf_exp              = 1'b0;
      ovf_exp              = 1'b0;
      pf_model             = 1'b0;
      timed_out            = 1'b0;
      val_errs             = 0;
      other_errs           = 0;
      sgl_inj              = 0;
      dbl_inj              = 0;
      sgl_seen             = 0;
      dbl_seen             = 0;

      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      #1;
      check_reset_state();
      mon_on = 1'b1;

      fd = $fopen("verif/fwft_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open verif/fwft_cases.txt");
         other_errs++;
      end else begin
         while (!timed_out && $fgets(line, fd) > 0) begin
            run_line(line);
         end
         $fclose(fd);
      end

      if (!timed_out) drain_fifo();
      assert (sgl_seen == sgl_inj) else flag_mismatch("single_err pulses", sgl_inj, sgl_seen);
      assert (dbl_seen == dbl_inj) else flag_mismatch("double_err pulses", dbl_inj, dbl_seen);

      $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/fwft_fifo.sv
`default_nettype none

`include "fifo_cfg.svh"

module fwft_fifo import fifo_pkg::*; (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        wr_en,
   input  logic                        inj_single,   // flip codeword bit 0
   input  logic                        inj_double,   // flip codeword bits 0 and 1
   input  logic                        rd_en,
   input  logic [`FIFO_DATA_WIDTH-1:0] wr_data,
   input  fifo_level_t                 prog_full_assert_cfg,
   input  fifo_level_t                 prog_full_negate_cfg,
   output logic [`FIFO_DATA_WIDTH-1:0] rd_data,
   output logic                        rd_data_val,
   output logic                        empty,
   output logic                        full,
   output logic                        prog_full,
   output logic                        ovf_int,
   output logic                        udf_int,
   output logic                        single_err,
   output logic                        double_err
);

   localparam int               SLOTS     = `FIFO_PRE_SLOTS;
   localparam int               PIPE      = `FIFO_RAM_PIPE;
   localparam int               DATA_W    = `FIFO_DATA_WIDTH;
   localparam logic [SLOTS-1:0] RING_INIT = {{(SLOTS-1){1'b0}}, 1'b1};

   logic [DATA_W-1:0] pre_data [SLOTS];
   logic [SLOTS-1:0]  pre_val;
   logic [SLOTS-1:0]  in_ring, in_ring_dly;         // slot tag at issue / at return
   logic [SLOTS-1:0]  out_ring;                     // slot shown on the output
   logic              core_rd_en, core_rd_val, core_empty;
   logic [DATA_W-1:0] core_rd_data;
   logic              pop;

   assign pop         = rd_en & rd_data_val;
   assign rd_data_val = |(pre_val & out_ring);
   assign empty       = ~rd_data_val;

   // only fetch when the tagged slot is free
   assign core_rd_en = ~core_empty & ~|(in_ring & pre_val);

   // ----------------------------------------------------------------------
   // slot rings
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_ring  <= RING_INIT;
         out_ring <= RING_INIT;
      end else begin
         if (core_rd_en) in_ring <= {in_ring[SLOTS-2:0], in_ring[SLOTS-1]};
         if (pop) out_ring <= {out_ring[SLOTS-2:0], out_ring[SLOTS-1]};
      end
   end

   bus_delay #(
      .DELAY_CYCLES (PIPE),
      .BUS_WIDTH    (SLOTS),
      .INIT_VAL     (RING_INIT)
   ) u_tag_delay (
      .clk    (clk),
      .rst_n  (rst_n),
      .inbus  (in_ring),
      .outbus (in_ring_dly)
   );

   // ----------------------------------------------------------------------
   // prefetch slots
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pre_val <= '0;
      end else begin
         for (int i = 0; i < SLOTS; i++) begin
            if (core_rd_val && in_ring_dly[i]) pre_val[i] <= 1'b1;
            else if (pop && out_ring[i]) pre_val[i] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < SLOTS; i++) begin
         if (core_rd_val && in_ring_dly[i]) pre_data[i] <= core_rd_data;
      end
   end

   // one-hot mask then or-reduce
   always_comb begin
      rd_data = '0;
      for (int i = 0; i < SLOTS; i++) begin
         rd_data = rd_data | (pre_data[i] & {DATA_W{out_ring[i]}});
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         udf_int <= 1'b0;
      end else begin
         udf_int <= rd_en & ~rd_data_val;           // pop with nothing shown
      end
   end

   fifo_core u_core (
      .clk                  (clk),
      .rst_n                (rst_n),
      .wr_en                (wr_en),
      .inj_single           (inj_single),
      .inj_double           (inj_double),
      .rd_en                (core_rd_en),
      .wr_data              (wr_data),
      .prog_full_assert_cfg (prog_full_assert_cfg),
      .prog_full_negate_cfg (prog_full_negate_cfg),
      .rd_data              (core_rd_data),
      .rd_val               (core_rd_val),
      .empty                (core_empty),
      .full                 (full),
      .prog_full            (prog_full),
      .ovf_int              (ovf_int),
      .single_err           (single_err),
      .double_err           (double_err)
   );

   a_rings_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot(in_ring) && $onehot(out_ring));

   // returned word must find its slot empty
   a_no_overwrite : assert property (@(posedge clk) disable iff (!rst_n)
      core_rd_val |-> ((in_ring_dly & pre_val) == '0));

endmodule

`default_nettype wire

// File: logic/fifo_core.sv
`default_nettype none

`include "fifo_cfg.svh"

module fifo_core import ecc_pkg::*, fifo_pkg::*; (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        wr_en,
   input  logic                        inj_single,
   input  logic                        inj_double,
   input  logic                        rd_en,
   input  logic [`FIFO_DATA_WIDTH-1:0] wr_data,
   input  fifo_level_t                 prog_full_assert_cfg,
   input  fifo_level_t                 prog_full_negate_cfg,
   output logic [`FIFO_DATA_WIDTH-1:0] rd_data,
   output logic                        rd_val,
   output logic                        empty,
   output logic                        full,
   output logic                        prog_full,
   output logic                        ovf_int,
   output logic                        single_err,
   output logic                        double_err
);

   localparam int          ADDR_W = `FIFO_ADDR_WIDTH;
   localparam int          PIPE   = `FIFO_RAM_PIPE;
   localparam fifo_level_t DEPTH  = fifo_level_t'(1 << ADDR_W);

   fifo_ptr_t     wr_ptr, wr_ptr_nxt;
   fifo_ptr_t     rd_ptr, rd_ptr_nxt;
   fifo_level_t   level, level_nxt;
   logic          wr_ok, rd_ok;
   logic [PIPE:0] vld;                              // [0] is the accepted read
   ecc_codeword_t enc_word, wr_word, rd_word;

   // ----------------------------------------------------------------------
   // pointers and flags
   // ----------------------------------------------------------------------

   assign wr_ok = wr_en & ~full;
   assign rd_ok = rd_en & ~empty;

   assign wr_ptr_nxt = wr_ptr + fifo_ptr_t'(wr_ok);
   assign rd_ptr_nxt = rd_ptr + fifo_ptr_t'(rd_ok);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         wr_ptr <= wr_ptr_nxt;
         rd_ptr <= rd_ptr_nxt;
      end
   end

   assign level     = fifo_level(wr_ptr, rd_ptr);
   assign level_nxt = fifo_level(wr_ptr_nxt, rd_ptr_nxt);
   assign empty     = (wr_ptr == rd_ptr);
   assign full      = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                      (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   // hysteresis, looks at next level so it moves with full and empty
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         prog_full <= 1'b0;
      end else if (level_nxt >= prog_full_assert_cfg) begin
         prog_full <= 1'b1;
      end else if (level_nxt < prog_full_negate_cfg) begin
         prog_full <= 1'b0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ovf_int <= 1'b0;
      end else begin
         ovf_int <= wr_en & full;                   // dropped write
      end
   end

   // ----------------------------------------------------------------------
   // ecc and storage
   // ----------------------------------------------------------------------

   // injection works on the raw view, bit 0 alone or bits 0 and 1
   assign wr_word.raw = enc_word.raw ^
                        {{($bits(ecc_codeword_t)-2){1'b0}}, inj_double, inj_single | inj_double};

   pipe_ram #(
      .ADDR_W  (ADDR_W),
      .PIPE    (PIPE)
   ) u_ram (
      .clk     (clk),
      .wr_en   (wr_ok),
      .wr_addr (wr_ptr[ADDR_W-1:0]),
      .rd_addr (rd_ptr[ADDR_W-1:0]),
      .wr_word (wr_word),
      .rd_word (rd_word)
   );

   secded_codec u_codec (
      .clk        (clk),
      .rst_n      (rst_n),
      .enc_data   (wr_data),
      .enc_word   (enc_word),
      .dec_word   (rd_word),
      .dec_en     (vld[PIPE-1]),                   // word at the decoder input
      .dec_data   (rd_data),
      .single_err (single_err),
      .double_err (double_err)
   );

   // read valid follows the data through the ram and decoder
   assign vld[0] = rd_ok;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld[PIPE:1] <= '0;
      end else begin
         vld[PIPE:1] <= vld[PIPE-1:0];
      end
   end

   assign rd_val = vld[PIPE];

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------

   a_no_rd_empty : assert property (@(posedge clk) disable iff (!rst_n)
      rd_en |-> !empty);

   a_level_max : assert property (@(posedge clk) disable iff (!rst_n)
      level <= DEPTH);

endmodule

`default_nettype wire

// File: logic/bus_delay.sv
`default_nettype none

module bus_delay #(
   parameter int                   DELAY_CYCLES = 2,
   parameter int                   BUS_WIDTH    = 4,
   parameter logic [BUS_WIDTH-1:0] INIT_VAL     = '0
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [BUS_WIDTH-1:0] inbus,
   output logic [BUS_WIDTH-1:0] outbus
);

   logic [BUS_WIDTH-1:0] stage [DELAY_CYCLES];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DELAY_CYCLES; i++) begin
            stage[i] <= INIT_VAL;                   // every stage, not just the tail
         end
      end else begin
         stage[0] <= inbus;
         for (int i = 1; i < DELAY_CYCLES; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   assign outbus = stage[DELAY_CYCLES-1];

endmodule

`default_nettype wire

// File: logic/pipe_ram.sv
`default_nettype none

module pipe_ram import ecc_pkg::*; #(
   parameter int ADDR_W = 4,
   parameter int PIPE   = 2     // total read latency incl. the decode register
) (
   input  logic              clk,
   input  logic              wr_en,
   input  logic [ADDR_W-1:0] wr_addr,
   input  logic [ADDR_W-1:0] rd_addr,
   input  ecc_codeword_t     wr_word,
   output ecc_codeword_t     rd_word
);

   ecc_codeword_t mem [2**ADDR_W];

   // ----------------------------------------------------------------------
   // write port
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_word;
      end
   end

   // ----------------------------------------------------------------------
   // read port
   // ----------------------------------------------------------------------

   // PIPE-1 stages here, the decoder adds the last one
   generate
      if (PIPE < 1) begin : g_bad_pipe
         $error("pipe_ram needs PIPE >= 1");
      end else if (PIPE == 1) begin : g_comb_rd
         assign rd_word = mem[rd_addr];              // decoder register only
      end else begin : g_reg_rd
         ecc_codeword_t stage [PIPE-1];

         always_ff @(posedge clk) begin
            stage[0] <= mem[rd_addr];
            for (int i = 1; i < PIPE - 1; i++) begin
               stage[i] <= stage[i-1];
            end
         end

         assign rd_word = stage[PIPE-2];
      end
   endgenerate

endmodule

`default_nettype wire

// File: logic/secded_codec.sv
`default_nettype none

`include "fifo_cfg.svh"

module secded_codec import ecc_pkg::*; (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [`FIFO_DATA_WIDTH-1:0] enc_data,    // write side payload
   output ecc_codeword_t               enc_word,
   input  ecc_codeword_t               dec_word,    // codeword from the ram
   input  logic                        dec_en,      // dec_word is a real read
   output logic [`FIFO_DATA_WIDTH-1:0] dec_data,
   output logic                        single_err,
   output logic                        double_err
);

   localparam int DATA_W = `FIFO_DATA_WIDTH;
   localparam int CW_W   = $bits(ecc_codeword_t);

   ecc_syndrome_t             syn;
   logic                      par_odd;
   logic [DATA_W-1:0]         fixed_data;

   // hamming position of a raw bit index, check bits sit on powers of two
   function automatic int unsigned ham_pos(input int unsigned idx);
      int unsigned pos;
      int unsigned cnt;
      pos = 0;
      cnt = 0;
      if (idx >= DATA_W) begin
         pos = 1 << (idx - DATA_W);
      end else begin
         for (int unsigned p = 1; p < CW_W; p++) begin
            if ((p & (p - 1)) != 0) begin           // skip check positions
               if (cnt == idx) pos = p;
               cnt++;
            end
         end
      end
      return pos;
   endfunction

   // xor of the positions of all set bits, overall parity excluded
   function automatic ecc_syndrome_t raw_syndrome(input logic [CW_W-1:0] w);
      ecc_syndrome_t s;
      s = '0;
      for (int unsigned i = 0; i < CW_W - 1; i++) begin
         if (w[i]) s = s ^ ecc_syndrome_t'(ham_pos(i));
      end
      return s;
   endfunction

   // ----------------------------------------------------------------------
   // encoder
   // ----------------------------------------------------------------------

   always_comb begin
      ecc_codeword_t tmp;
      tmp           = '0;
      tmp.fld.data  = enc_data;
      tmp.fld.chk   = raw_syndrome(tmp.raw);        // check bits still zero here
      tmp.fld.p_all = ^tmp.raw[CW_W-2:0];
      enc_word      = tmp;
   end

   // ----------------------------------------------------------------------
   // decoder
   // ----------------------------------------------------------------------

   assign syn     = raw_syndrome(dec_word.raw);
   assign par_odd = ^dec_word.raw;                  // clean word has even parity

   // a syndrome on a check position leaves the data alone
   always_comb begin
      fixed_data = dec_word.fld.data;
      for (int unsigned i = 0; i < DATA_W; i++) begin
         if (syn == ecc_syndrome_t'(ham_pos(i))) fixed_data[i] = ~fixed_data[i];
      end
   end

   always_ff @(posedge clk) begin
      dec_data <= fixed_data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         single_err <= 1'b0;
         double_err <= 1'b0;
      end else begin
         single_err <= dec_en & par_odd;
         double_err <= dec_en & ~par_odd & (syn != '0);
      end
   end

endmodule

`default_nettype wire

// File: logic/fifo_pkg.sv
`default_nettype none

`include "fifo_cfg.svh"

package fifo_pkg;

   // ----------------------------------------------------------------------
   // pointer and level types
   // ----------------------------------------------------------------------

   // one wrap bit above the address so full and empty can be told apart
   typedef logic [`FIFO_ADDR_WIDTH:0] fifo_ptr_t;

   // 0 .. depth, same type for the prog full thresholds
   typedef logic [`FIFO_ADDR_WIDTH:0] fifo_level_t;

   // occupancy from a pointer pair, modulo arithmetic handles the wrap
   function automatic fifo_level_t fifo_level(input fifo_ptr_t wr,
                                              input fifo_ptr_t rd);
      return fifo_level_t'(wr - rd);
   endfunction

endpackage

`default_nettype wire

// File: logic/ecc_pkg.sv
`default_nettype none

`include "fifo_cfg.svh"

package ecc_pkg;

   // ----------------------------------------------------------------------
   // secded codeword
   // ----------------------------------------------------------------------

   // hamming syndrome, also the width of the check field
   typedef logic [4:0] ecc_syndrome_t;

   // 16 data bits, 5 hamming check bits, 1 overall parity bit
   // raw view is what the syndrome logic and the injection flips see,
   // field view is what the encoder packs and the decoder unpacks
   typedef union packed {
      logic [`FIFO_DATA_WIDTH+5:0] raw;        // whole word, data in the low bits
      struct packed {
         logic                       p_all;    // even parity over the other 21 bits
         ecc_syndrome_t              chk;      // check bit k at hamming position 2**k
         logic [`FIFO_DATA_WIDTH-1:0] data;    // payload
      } fld;
   } ecc_codeword_t;

   // raw bit layout
   //    [15:0]  data, placed on the non power of two positions 3,5,6,7,9..
   //    [20:16] check bits for positions 1,2,4,8,16
   //    [21]    overall parity
   //
   // an error in raw bit 0 is a data error at position 3, raw bit 1 at
   // position 5, so injecting on both gives a non-zero syndrome with even
   // overall parity

endpackage

`default_nettype wire

// File: logic/fifo_cfg.svh
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// ----------------------------------------------------------------------
// fifo geometry
// ----------------------------------------------------------------------

// core address width, depth is 2**width
`define FIFO_ADDR_WIDTH 4

// payload width, the secded code is built for exactly 16 bits
`define FIFO_DATA_WIDTH 16

// ----------------------------------------------------------------------
// read timing
// ----------------------------------------------------------------------

// cycles from core read strobe to returned data, at least 1
`define FIFO_RAM_PIPE 2

// prefetch slots in front of the core
// two more than the read latency so the pipe never stalls on a pop
`define FIFO_PRE_SLOTS (`FIFO_RAM_PIPE + 2)

`endif
